// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP     = tb_exu
FILES   = all.f
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_ctrl.sv
hdl/exu_datapath.sv
hdl/exu_top.sv
tests/tb_exu.sv

// File: hdl/exu_alu.sv
//**************************************************************************
// combinational RV32 integer ALU used by the execute-stage datapath
//**************************************************************************
`timescale 1ns/100ps

module exu_alu (
	input  exu_pkg::alu_op_t           op_i,
	input  logic [exu_pkg::XLEN-1:0]   src1_i,
	input  logic [exu_pkg::XLEN-1:0]   src2_i,
	output logic [exu_pkg::XLEN-1:0]   result_o
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// only the low five bits count for RV32 shifts
	assign shamt = src2_i[4:0];

	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		case (op_i)
			exu_pkg::ALU_ADD: begin
				result_o = src1_i + src2_i;
			end
			exu_pkg::ALU_SUB: begin
				result_o = src1_i - src2_i;
			end
			exu_pkg::ALU_SLL: begin
				result_o = src1_i << shamt;
			end
			exu_pkg::ALU_SLT: begin
				result_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_signed};
			end
			exu_pkg::ALU_SLTU: begin
				result_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_unsigned};
			end
			exu_pkg::ALU_XOR: begin
				result_o = src1_i ^ src2_i;
			end
			exu_pkg::ALU_SRL: begin
				result_o = src1_i >> shamt;
			end
			exu_pkg::ALU_SRA: begin
				// arithmetic shift keeps the sign bit
				result_o = $unsigned($signed(src1_i) >>> shamt);
			end
			exu_pkg::ALU_OR: begin
				result_o = src1_i | src2_i;
			end
			exu_pkg::ALU_AND: begin
				result_o = src1_i & src2_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// File: hdl/exu_ctrl.sv
//**************************************************************************
// execute-stage handshake FSM and instruction bundle register
//**************************************************************************
`timescale 1ns/100ps

module exu_ctrl (
	input  logic             clock,
	input  logic             reset,
	input  logic             idu_valid_i,
	output logic             exu_ready_o,
	input  logic             lsu_ready_i,
	output logic             exu_valid_o,
	input  exu_pkg::exu_in_t bundle_i,
	output exu_pkg::exu_in_t bundle_o
);

	logic [1:0]       state_q;
	logic [1:0]       state_d;
	logic             accept;
	exu_pkg::exu_in_t bundle_q;

	assign exu_ready_o = (state_q == exu_pkg::ST_IDLE);
	assign exu_valid_o = (state_q == exu_pkg::ST_RUN) || (state_q == exu_pkg::ST_WAIT);
	assign accept      = idu_valid_i && exu_ready_o;

	always_comb begin
		state_d = state_q;
		case (state_q)
			exu_pkg::ST_IDLE: begin
				if (accept) begin
					state_d = exu_pkg::ST_RUN;
				end
			end
			exu_pkg::ST_RUN: begin
				state_d = lsu_ready_i ? exu_pkg::ST_IDLE : exu_pkg::ST_WAIT;
			end
			exu_pkg::ST_WAIT: begin
				// hold until the load/store stage takes the result
				if (lsu_ready_i) begin
					state_d = exu_pkg::ST_IDLE;
				end
			end
			default: begin
				state_d = exu_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= exu_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// only a new acceptance replaces the held instruction
	always_ff @(posedge clock) begin
		if (accept) begin
			bundle_q <= bundle_i;
		end
	end

	assign bundle_o = bundle_q;

	// back-pressure keeps the result the load/store stage sees
	a_hold_under_stall: assert property (@(posedge clock) disable iff (reset)
		(exu_valid_o && !lsu_ready_i) |=> $stable(bundle_o))
		else $error("exu bundle changed while stalled");

	a_legal_state: assert property (@(posedge clock) disable iff (reset)
		state_q != 2'b11)
		else $error("exu controller in illegal state");

endmodule

// File: hdl/exu_datapath.sv
//**************************************************************************
// operand selection, ALU and CSR write data for the held instruction
// purely combinational, the result follows bundle_i in the same cycle
//**************************************************************************
`timescale 1ns/100ps

module exu_datapath (
	input  exu_pkg::exu_in_t  bundle_i,
	output exu_pkg::exu_out_t result_o
);

	logic [exu_pkg::XLEN-1:0] src1;
	logic [exu_pkg::XLEN-1:0] src2;
	logic [exu_pkg::XLEN-1:0] alu_result;
	logic [exu_pkg::XLEN-1:0] csr_wdata;

	// first alu operand
	always_comb begin
		case (bundle_i.src1_sel)
			exu_pkg::SRC1_REG1: src1 = bundle_i.reg1;
			exu_pkg::SRC1_PC:   src1 = bundle_i.pc;
			exu_pkg::SRC1_CSR:  src1 = bundle_i.csr_rdata;
			default:            src1 = '0;
		endcase
	end

	// second alu operand, four for the link address
	always_comb begin
		case (bundle_i.src2_sel)
			exu_pkg::SRC2_REG2: src2 = bundle_i.reg2;
			exu_pkg::SRC2_IMM:  src2 = bundle_i.imm;
			exu_pkg::SRC2_FOUR: src2 = 32'd4;
			default:            src2 = '0;
		endcase
	end

	exu_alu alu_i (
		.op_i     (bundle_i.alu_op),
		.src1_i   (src1),
		.src2_i   (src2),
		.result_o (alu_result)
	);

	// ecall saves the faulting pc into mepc
	always_comb begin
		case (bundle_i.csr_flag)
			exu_pkg::CSR_CSRRW: csr_wdata = bundle_i.reg1;
			exu_pkg::CSR_CSRRS: csr_wdata = bundle_i.reg1 | bundle_i.csr_rdata;
			exu_pkg::CSR_ECALL: csr_wdata = bundle_i.pc;
			default:            csr_wdata = '0;
		endcase
	end

	assign result_o.alu_result = alu_result;
	assign result_o.csr_wdata  = csr_wdata;

	// store data always comes from rs2
	assign result_o.mem_wdata  = bundle_i.reg2;

	assign result_o.pc         = bundle_i.pc;
	assign result_o.load_type  = bundle_i.load_type;
	assign result_o.store_type = bundle_i.store_type;
	assign result_o.wd         = bundle_i.wd;
	assign result_o.wreg       = bundle_i.wreg;
	assign result_o.csr_waddr  = bundle_i.csr_waddr;
	assign result_o.csr_type   = bundle_i.csr_flag;
	assign result_o.ebreak     = bundle_i.ebreak;

endmodule

// File: hdl/exu_pkg.sv
//**************************************************************************
// shared widths, operation codes and bundle types for the execute stage
// referenced by scoped names from every execute-stage module
//**************************************************************************
package exu_pkg;

	localparam int XLEN = 32;

	typedef logic [3:0] alu_op_t;
	typedef logic [1:0] src1_sel_t;
	typedef logic [1:0] src2_sel_t;
	typedef logic [2:0] csr_flag_t;

	// alu operations, any other code gives zero
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_SLL  = 4'd2;
	localparam alu_op_t ALU_SLT  = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR  = 4'd5;
	localparam alu_op_t ALU_SRL  = 4'd6;
	localparam alu_op_t ALU_SRA  = 4'd7;
	localparam alu_op_t ALU_OR   = 4'd8;
	localparam alu_op_t ALU_AND  = 4'd9;

	// first operand source
	localparam src1_sel_t SRC1_ZERO = 2'd0;
	localparam src1_sel_t SRC1_REG1 = 2'd1;
	localparam src1_sel_t SRC1_PC   = 2'd2;
	localparam src1_sel_t SRC1_CSR  = 2'd3;

	// second operand source
	localparam src2_sel_t SRC2_ZERO = 2'd0;
	localparam src2_sel_t SRC2_REG2 = 2'd1;
	localparam src2_sel_t SRC2_IMM  = 2'd2;
	localparam src2_sel_t SRC2_FOUR = 2'd3;

	// csr access kind, other values write zero
	localparam csr_flag_t CSR_NONE  = 3'd0;
	localparam csr_flag_t CSR_CSRRW = 3'd1;
	localparam csr_flag_t CSR_CSRRS = 3'd2;
	localparam csr_flag_t CSR_ECALL = 3'd3;

	// mcause value the csr file stores on ecall from machine mode
	localparam logic [XLEN-1:0] ECALL_CAUSE = 32'd11;

	// handshake controller states
	localparam logic [1:0] ST_IDLE = 2'b00;
	localparam logic [1:0] ST_RUN  = 2'b01;
	localparam logic [1:0] ST_WAIT = 2'b10;

	// decoded instruction from the decode stage
	typedef struct packed {
		logic [XLEN-1:0] reg1;
		logic [XLEN-1:0] reg2;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] csr_rdata;
		logic [11:0]     csr_waddr;
		csr_flag_t       csr_flag;
		alu_op_t         alu_op;
		src1_sel_t       src1_sel;
		src2_sel_t       src2_sel;
		logic            wd;
		logic [4:0]      wreg;
		logic [1:0]      store_type;
		logic [2:0]      load_type;
		logic            ebreak;
	} exu_in_t;

	// result handed to the load/store stage
	typedef struct packed {
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] mem_wdata;
		logic [XLEN-1:0] csr_wdata;
		logic [XLEN-1:0] pc;
		logic [2:0]      load_type;
		logic [1:0]      store_type;
		logic            wd;
		logic [4:0]      wreg;
		logic [11:0]     csr_waddr;
		csr_flag_t       csr_type;
		logic            ebreak;
	} exu_out_t;

endpackage

// File: hdl/exu_top.sv
//**************************************************************************
// execute stage between decode and load/store, one instruction at a time
//**************************************************************************
`timescale 1ns/100ps

module exu_top (
	input  logic              clock,
	input  logic              reset,
	input  logic              idu_valid_i,
	output logic              exu_ready_o,
	input  exu_pkg::exu_in_t  bundle_i,
	input  logic              lsu_ready_i,
	output logic              exu_valid_o,
	output exu_pkg::exu_out_t result_o
);

	// instruction held by the controller
	exu_pkg::exu_in_t bundle_q;

	exu_ctrl ctrl_i (
		.clock       (clock),
		.reset       (reset),
		.idu_valid_i (idu_valid_i),
		.exu_ready_o (exu_ready_o),
		.lsu_ready_i (lsu_ready_i),
		.exu_valid_o (exu_valid_o),
		.bundle_i    (bundle_i),
		.bundle_o    (bundle_q)
	);

	exu_datapath datapath_i (
		.bundle_i (bundle_q),
		.result_o (result_o)
	);

endmodule

// File: tests/tb_exu.sv
//**************************************************************************
// testbench for the execute stage, a directed table then random bundles
//**************************************************************************
`timescale 1ns/100ps

module tb_exu;

	localparam int CLK_PERIOD     = 4;
	localparam int NUM_ROWS       = 16;
	localparam int NUM_RAND       = 40;
	localparam int TIMEOUT_CYCLES = (NUM_ROWS + NUM_RAND) * 12;

	// fixed operands for the table rows
	localparam logic [31:0] T_REG1 = 32'h8000_0010;
	localparam logic [31:0] T_REG2 = 32'h0000_0023;
	localparam logic [31:0] T_PC   = 32'h0000_1000;
	localparam logic [31:0] T_IMM  = 32'hffff_fff0;
	localparam logic [31:0] T_CSR  = 32'h0000_00a5;

	typedef struct packed {
		exu_pkg::alu_op_t   op;
		exu_pkg::src1_sel_t src1_sel;
		exu_pkg::src2_sel_t src2_sel;
		exu_pkg::csr_flag_t csr_flag;
		logic [1:0]         stall;
		logic [31:0]        exp_alu;
	} row_t;

	logic              clock = 1'b0;
	logic              reset;
	logic              idu_valid;
	logic              exu_ready;
	logic              lsu_ready;
	logic              exu_valid;
	exu_pkg::exu_in_t  bundle;
	exu_pkg::exu_out_t result;

	row_t        rows [NUM_ROWS];
	int          errors = 0;
	logic [31:0] seed = 32'habc2;
	logic [31:0] exp_q [$];
	logic [31:0] seen_q [$];
	logic        valid_prev = 1'b0;
	logic [31:0] last_alu;

	exu_top dut_i (
		.clock       (clock),
		.reset       (reset),
		.idu_valid_i (idu_valid),
		.exu_ready_o (exu_ready),
		.bundle_i    (bundle),
		.lsu_ready_i (lsu_ready),
		.exu_valid_o (exu_valid),
		.result_o    (result)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		seed = xorshift32(seed);
		return seed;
	endfunction

	function automatic logic [31:0] alu_model(input exu_pkg::alu_op_t op,
			input logic [31:0] a, input logic [31:0] b);
		logic [4:0]  sh;
		logic [31:0] r;
		sh = b[4:0];
		case (op)
			exu_pkg::ALU_ADD:  r = a + b;
			exu_pkg::ALU_SUB:  r = a + ~b + 32'd1;
			exu_pkg::ALU_SLL:  r = a << sh;
			exu_pkg::ALU_SLT:  r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, (a < b)};
			exu_pkg::ALU_SLTU: r = {31'd0, (a < b)};
			exu_pkg::ALU_XOR:  r = a ^ b;
			exu_pkg::ALU_SRL:  r = a >> sh;
			// fill the vacated upper bits with the sign
			exu_pkg::ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
			exu_pkg::ALU_OR:   r = a | b;
			exu_pkg::ALU_AND:  r = a & b;
			default:           r = 32'd0;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] bundle_alu(input exu_pkg::exu_in_t b);
		logic [31:0] a;
		logic [31:0] c;
		case (b.src1_sel)
			exu_pkg::SRC1_REG1: a = b.reg1;
			exu_pkg::SRC1_PC:   a = b.pc;
			exu_pkg::SRC1_CSR:  a = b.csr_rdata;
			default:            a = 32'd0;
		endcase
		case (b.src2_sel)
			exu_pkg::SRC2_REG2: c = b.reg2;
			exu_pkg::SRC2_IMM:  c = b.imm;
			exu_pkg::SRC2_FOUR: c = 32'd4;
			default:            c = 32'd0;
		endcase
		return alu_model(b.alu_op, a, c);
	endfunction

	function automatic exu_pkg::exu_out_t expected_out(input exu_pkg::exu_in_t b,
			input logic [31:0] alu);
		exu_pkg::exu_out_t o;
		o.alu_result = alu;
		o.mem_wdata  = b.reg2;
		case (b.csr_flag)
			exu_pkg::CSR_CSRRW: o.csr_wdata = b.reg1;
			exu_pkg::CSR_CSRRS: o.csr_wdata = b.reg1 | b.csr_rdata;
			exu_pkg::CSR_ECALL: o.csr_wdata = b.pc;
			default:            o.csr_wdata = 32'd0;
		endcase
		o.pc         = b.pc;
		o.load_type  = b.load_type;
		o.store_type = b.store_type;
		o.wd         = b.wd;
		o.wreg       = b.wreg;
		o.csr_waddr  = b.csr_waddr;
		o.csr_type   = b.csr_flag;
		o.ebreak     = b.ebreak;
		return o;
	endfunction

	task automatic check_value(input string name, input logic [31:0] act,
			input logic [31:0] exp);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, act, exp);
		end
	endtask

	task automatic check_result(input exu_pkg::exu_out_t exp);
		check_value("exu_valid_o", 32'(exu_valid), 32'd1);
		check_value("exu_ready_o", 32'(exu_ready), 32'd0);
		check_value("alu_result", result.alu_result, exp.alu_result);
		check_value("mem_wdata", result.mem_wdata, exp.mem_wdata);
		check_value("csr_wdata", result.csr_wdata, exp.csr_wdata);
		check_value("pc", result.pc, exp.pc);
		check_value("load_type", 32'(result.load_type), 32'(exp.load_type));
		check_value("store_type", 32'(result.store_type), 32'(exp.store_type));
		check_value("wd", 32'(result.wd), 32'(exp.wd));
		check_value("wreg", 32'(result.wreg), 32'(exp.wreg));
		check_value("csr_waddr", 32'(result.csr_waddr), 32'(exp.csr_waddr));
		check_value("csr_type", 32'(result.csr_type), 32'(exp.csr_type));
		check_value("ebreak", 32'(result.ebreak), 32'(exp.ebreak));
	endtask

	// entered on a falling edge, returns on the falling edge after the transfer
	task automatic run_bundle(input exu_pkg::exu_in_t b, input exu_pkg::exu_out_t exp,
			input int stall, input logic hold_valid);
		int k;
		bundle    = b;
		idu_valid = 1'b1;
		lsu_ready = (stall == 0);
		while (!exu_ready) begin
			@(negedge clock);
		end
		exp_q.push_back(exp.alu_result);
		@(negedge clock);
		check_result(exp);
		// a new bundle on offer must not replace the held one
		if (hold_valid) begin
			bundle = exu_pkg::exu_in_t'(~b);
		end else begin
			idu_valid = 1'b0;
		end
		for (k = 1; k <= stall; k++) begin
			@(negedge clock);
			check_result(exp);
			if (k == stall) begin
				lsu_ready = 1'b1;
			end
		end
		@(negedge clock);
		check_value("exu_valid_o", 32'(exu_valid), 32'd0);
		check_value("exu_ready_o", 32'(exu_ready), 32'd1);
		lsu_ready = 1'b0;
	endtask

	// record each transfer as valid falls, and catch valid with ready
	always @(negedge clock) begin
		if (!reset) begin
			if (exu_valid && exu_ready) begin
				errors++;
				$display("exu_valid_o and exu_ready_o were both high at %0t ns", $time);
			end
			if (valid_prev && !exu_valid) begin
				seen_q.push_back(last_alu);
			end
			valid_prev = exu_valid;
			last_alu   = result.alu_result;
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: the execute stage stopped completing handshakes");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int                i;
		int                stall;
		logic [31:0]       rnd;
		exu_pkg::exu_in_t  b;
		// op, src1 sel, src2 sel, csr flag, stall cycles, expected alu result
		rows[0]  = '{4'd0,  2'd1, 2'd1, 3'd0, 2'd0, 32'h8000_0033};
		rows[1]  = '{4'd1,  2'd1, 2'd1, 3'd0, 2'd1, 32'h7fff_ffed};
		rows[2]  = '{4'd2,  2'd1, 2'd1, 3'd0, 2'd0, 32'h0000_0080};
		rows[3]  = '{4'd3,  2'd1, 2'd1, 3'd0, 2'd2, 32'h0000_0001};
		rows[4]  = '{4'd4,  2'd1, 2'd1, 3'd0, 2'd0, 32'h0000_0000};
		rows[5]  = '{4'd5,  2'd1, 2'd2, 3'd0, 2'd3, 32'h7fff_ffe0};
		rows[6]  = '{4'd6,  2'd1, 2'd1, 3'd0, 2'd0, 32'h1000_0002};
		rows[7]  = '{4'd7,  2'd1, 2'd1, 3'd0, 2'd1, 32'hf000_0002};
		rows[8]  = '{4'd8,  2'd1, 2'd2, 3'd0, 2'd0, 32'hffff_fff0};
		rows[9]  = '{4'd9,  2'd1, 2'd2, 3'd0, 2'd2, 32'h8000_0010};
		rows[10] = '{4'd0,  2'd2, 2'd3, 3'd0, 2'd0, 32'h0000_1004};
		rows[11] = '{4'd0,  2'd2, 2'd2, 3'd0, 2'd1, 32'h0000_0ff0};
		rows[12] = '{4'd0,  2'd0, 2'd2, 3'd0, 2'd0, 32'hffff_fff0};
		rows[13] = '{4'd8,  2'd3, 2'd0, 3'd2, 2'd3, 32'h0000_00a5};
		rows[14] = '{4'd0,  2'd3, 2'd0, 3'd1, 2'd0, 32'h0000_00a5};
		rows[15] = '{4'd12, 2'd1, 2'd1, 3'd3, 2'd1, 32'h0000_0000};
		reset     = 1'b1;
		idu_valid = 1'b0;
		lsu_ready = 1'b0;
		bundle    = '0;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		check_value("exu_ready_o", 32'(exu_ready), 32'd1);
		check_value("exu_valid_o", 32'(exu_valid), 32'd0);
		b = '0;
		b.reg1      = T_REG1;
		b.reg2      = T_REG2;
		b.pc        = T_PC;
		b.imm       = T_IMM;
		b.csr_rdata = T_CSR;
		for (i = 0; i < NUM_ROWS; i++) begin
			b.alu_op     = rows[i].op;
			b.src1_sel   = rows[i].src1_sel;
			b.src2_sel   = rows[i].src2_sel;
			b.csr_flag   = rows[i].csr_flag;
			b.csr_waddr  = 12'h300 + 12'(i);
			b.wd         = i[0];
			b.wreg       = i[4:0];
			b.store_type = i[1:0];
			b.load_type  = i[2:0];
			b.ebreak     = (i == NUM_ROWS - 1);
			run_bundle(b, expected_out(b, rows[i].exp_alu), int'(rows[i].stall), 1'b0);
		end
		// random bundles with idu_valid held high throughout
		for (i = 0; i < NUM_RAND; i++) begin
			b.reg1       = next_rand();
			b.reg2       = next_rand();
			b.pc         = next_rand();
			b.imm        = next_rand();
			b.csr_rdata  = next_rand();
			b.csr_waddr  = 12'(next_rand() >> 20);
			rnd          = next_rand();
			b.alu_op     = rnd[3:0];
			b.src1_sel   = rnd[5:4];
			b.src2_sel   = rnd[7:6];
			b.csr_flag   = rnd[10:8];
			b.wd         = rnd[11];
			b.wreg       = rnd[16:12];
			b.store_type = rnd[18:17];
			b.load_type  = rnd[21:19];
			b.ebreak     = rnd[22];
			stall        = int'(rnd[25:24]);
			// the csr operand only comes with a csr access
			if (b.csr_flag == exu_pkg::CSR_NONE && b.src1_sel == exu_pkg::SRC1_CSR) begin
				b.src1_sel = exu_pkg::SRC1_REG1;
			end
			run_bundle(b, expected_out(b, bundle_alu(b)), stall, 1'b1);
		end
		idu_valid = 1'b0;
		repeat (2) @(negedge clock);
		check_value("transfer count", 32'(seen_q.size()), 32'(exp_q.size()));
		if (seen_q.size() == exp_q.size()) begin
			for (i = 0; i < exp_q.size(); i++) begin
				check_value("transferred alu_result", seen_q[i], exp_q[i]);
			end
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
